/* rtl/bch_pkg.sv */
//------------------------------------------------
// bch (15,7) decoder shared definitions
// code constants, GF(16) element types and
// field arithmetic used by all decoder stages
//------------------------------------------------

package bch_pkg;

  //------------------------------------------------
  // code parameters
  //------------------------------------------------

  // field width and code length 2^m - 1
  localparam int m      = 4;
  localparam int n      = 15;
  localparam int k      = 7;
  // correctable errors and syndrome count
  localparam int t      = 2;
  localparam int t2     = 2 * t;
  // x^4 + x + 1
  localparam int irrpol = 19;

  //------------------------------------------------
  // types
  //------------------------------------------------

  typedef logic [m-1:0] gf_t;
  // bank pointer, sized for four banks
  typedef logic [1:0]   ptr_t;
  // bit position inside a word
  typedef logic [3:0]   addr_t;

  //------------------------------------------------
  // field arithmetic
  //------------------------------------------------

  // carry-less product followed by reduction modulo irrpol
  function automatic gf_t gf_mult(gf_t a, gf_t b);
    logic [2*m-2:0] prod;
    logic [2*m-2:0] aw;
    logic [2*m-2:0] poly;
    prod = '0;
    aw   = (2*m-1)'(a);
    poly = (2*m-1)'(irrpol);
    for (int i = 0; i < m; i++) begin
      if (b[i]) begin
        prod = prod ^ (aw << i);
      end
    end
    // fold the high terms back, top degree first
    for (int i = 2*m-2; i >= m; i--) begin
      if (prod[i]) begin
        prod = prod ^ (poly << (i - m));
      end
    end
    return prod[m-1:0];
  endfunction

  // alpha^e, exponent taken modulo n, negative values allowed
  function automatic gf_t gf_alpha_pow(int e);
    gf_t res;
    int  em;
    res = gf_t'(1);
    em  = ((e % n) + n) % n;
    // fixed bound keeps the loop static
    for (int i = 0; i < n; i++) begin
      if (i < em) begin
        res = gf_mult(res, gf_t'(2));
      end
    end
    return res;
  endfunction

endpackage

/* rtl/bch_if.sv */
//------------------------------------------------
// bch decoder inter-stage interfaces
// syndrome_if   syndrome counter to berlekamp
// loc_poly_if   berlekamp to chien search
//------------------------------------------------

`timescale 1ns/1ps

// syndromes of one word, val is a one cycle strobe
interface syndrome_if;

  logic          val;
  bch_pkg::ptr_t ptr;
  bch_pkg::gf_t  syn [1:bch_pkg::t2];

  modport src (output val, ptr, syn);
  modport dst (input  val, ptr, syn);

endinterface

// error locator polynomial of one word
interface loc_poly_if;

  logic           val;
  bch_pkg::ptr_t  ptr;
  // coefficients, lowest degree first
  bch_pkg::gf_t   poly [0:bch_pkg::t];
  // length register of the berlekamp run
  bch_pkg::addr_t deg;
  // more than t errors detected
  logic           decfail;

  modport src (output val, ptr, poly, deg, decfail);
  modport dst (input  val, ptr, poly, deg, decfail);

endinterface

/* rtl/bch_buffer.sv */
//------------------------------------------------
// bch word buffer
// banked single bit memory, one bank per word
// in flight, registered read data
//------------------------------------------------

`timescale 1ns/1ps

module bch_buffer #(
  parameter int pBNUM_W = 2
) (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  // write side, from the syndrome counter
  input  logic           iwrite,
  input  bch_pkg::ptr_t  iwptr,
  input  bch_pkg::addr_t iwaddr,
  input  logic           iwdata,
  // read side, from the chien search
  input  logic           iread,
  input  bch_pkg::ptr_t  irptr,
  input  bch_pkg::addr_t iraddr,
  output logic           ordata
);

  // bank select on top, bit position below
  localparam int addr_w = pBNUM_W + $bits(bch_pkg::addr_t);

  logic              mem [0:2**addr_w-1];
  logic [addr_w-1:0] waddr;
  logic [addr_w-1:0] raddr;

  // only the low pointer bits select a bank
  assign waddr = {iwptr[pBNUM_W-1:0], iwaddr};
  assign raddr = {irptr[pBNUM_W-1:0], iraddr};

  always_ff @(posedge iclk) begin
    if (iclkena & iwrite) begin
      mem[waddr] <= iwdata;
    end
  end

  // read data arrives one enabled cycle after the request
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ordata <= 1'b0;
    end else if (iclkena & iread) begin
      ordata <= mem[raddr];
    end
  end

endmodule

/* rtl/bch_syndrome_count.sv */
//------------------------------------------------
// bch syndrome counter
// serial horner accumulation of the odd syndromes,
// even ones by squaring, word stored to buffer
//------------------------------------------------

`timescale 1ns/1ps

module bch_syndrome_count #(
  parameter int pBNUM_W = 2
) (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           isop,
  input  logic           ival,
  input  logic           ieop,
  input  logic           idat,
  output logic           oram_write,
  output bch_pkg::ptr_t  oram_ptr,
  output bch_pkg::addr_t oram_addr,
  output logic           oram_data,
  syndrome_if.src        syn
);

  // accumulators for S1, S3 .. S(2t-1)
  bch_pkg::gf_t   acc     [0:bch_pkg::t-1];
  bch_pkg::gf_t   acc_nxt [0:bch_pkg::t-1];
  bch_pkg::gf_t   syn_nxt [1:bch_pkg::t2];
  bch_pkg::addr_t cnt;
  bch_pkg::addr_t waddr;
  logic [pBNUM_W-1:0] bank;

  // first bit is the highest degree coefficient
  always_comb begin
    for (int i = 0; i < bch_pkg::t; i++) begin
      acc_nxt[i] = bch_pkg::gf_mult(isop ? bch_pkg::gf_t'(0) : acc[i],
                                    bch_pkg::gf_alpha_pow(2*i + 1))
                   ^ bch_pkg::gf_t'(idat);
    end
  end

  // S(2j) = S(j)^2 in a binary code
  always_comb begin
    bch_pkg::gf_t s [1:bch_pkg::t2];
    for (int j = 1; j <= bch_pkg::t2; j++) begin
      if (j % 2 == 1) begin
        s[j] = acc_nxt[j/2];
      end else begin
        s[j] = bch_pkg::gf_mult(s[j/2], s[j/2]);
      end
    end
    syn_nxt = s;
  end

  assign waddr = isop ? bch_pkg::addr_t'(0) : cnt;

  //------------------------------------------------
  // control
  //------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      cnt        <= '0;
      bank       <= '0;
      oram_write <= 1'b0;
      syn.val    <= 1'b0;
    end else if (iclkena) begin
      oram_write <= ival;
      syn.val    <= ival & ieop;
      if (ival) begin
        cnt <= waddr + 1'b1;
      end
      // next word goes to the next bank
      if (ival & ieop) begin
        bank <= bank + 1'b1;
      end
    end
  end

  //------------------------------------------------
  // data path
  //------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      oram_ptr  <= bch_pkg::ptr_t'(bank);
      oram_addr <= waddr;
      oram_data <= idat;
      if (ival) begin
        acc <= acc_nxt;
      end
      // held until the next word ends
      if (ival & ieop) begin
        syn.syn <= syn_nxt;
        syn.ptr <= bch_pkg::ptr_t'(bank);
      end
    end
  end

endmodule

/* rtl/bch_berlekamp.sv */
//------------------------------------------------
// bch inverse-free berlekamp-massey unit
// t2 iterations, one per enabled cycle, give the
// error locator polynomial and its length
//------------------------------------------------

`timescale 1ns/1ps

module bch_berlekamp (
  input  logic    iclk,
  input  logic    ireset,
  input  logic    iclkena,
  syndrome_if.dst syn,
  loc_poly_if.src loc
);

  // locator and auxiliary polynomial, full 2t length inside
  bch_pkg::gf_t   lam      [0:bch_pkg::t2];
  bch_pkg::gf_t   bpol     [0:bch_pkg::t2];
  bch_pkg::gf_t   lam_nxt  [0:bch_pkg::t2];
  bch_pkg::gf_t   bpol_nxt [0:bch_pkg::t2];
  bch_pkg::gf_t   gamma;
  bch_pkg::gf_t   gamma_nxt;
  bch_pkg::gf_t   delta;
  bch_pkg::addr_t len;
  bch_pkg::addr_t len_nxt;
  bch_pkg::addr_t r;
  logic           busy;
  logic           swap;
  logic           last;

  //------------------------------------------------
  // discrepancy and update
  //------------------------------------------------

  // delta = sum lam(i) * S(r+1-i)
  always_comb begin
    int idx;
    delta = '0;
    for (int i = 0; i <= bch_pkg::t2; i++) begin
      idx = int'(r) + 1 - i;
      if (idx >= 1 && idx <= bch_pkg::t2) begin
        delta = delta ^ bch_pkg::gf_mult(lam[i], syn.syn[idx]);
      end
    end
  end

  // length change only when 2L <= r
  assign swap = (delta != '0) && (2 * int'(len) <= int'(r));

  // lam = gamma*lam - delta*x*B, minus is xor here
  always_comb begin
    lam_nxt[0]  = bch_pkg::gf_mult(gamma, lam[0]);
    bpol_nxt[0] = swap ? lam[0] : bch_pkg::gf_t'(0);
    for (int i = 1; i <= bch_pkg::t2; i++) begin
      lam_nxt[i]  = bch_pkg::gf_mult(gamma, lam[i]) ^ bch_pkg::gf_mult(delta, bpol[i-1]);
      bpol_nxt[i] = swap ? lam[i] : bpol[i-1];
    end
  end

  assign gamma_nxt = swap ? delta : gamma;
  assign len_nxt   = swap ? (r + 1'b1 - len) : len;
  assign last      = busy & (r == bch_pkg::addr_t'(bch_pkg::t2 - 1));

  //------------------------------------------------
  // iteration control
  //------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy    <= 1'b0;
      r       <= '0;
      loc.val <= 1'b0;
    end else if (iclkena) begin
      loc.val <= last;
      if (syn.val) begin
        busy <= 1'b1;
        r    <= '0;
      end else if (busy) begin
        r <= r + 1'b1;
        if (last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  //------------------------------------------------
  // polynomial registers and result
  //------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (syn.val) begin
        // lam = B = 1, gamma = 1, L = 0
        for (int i = 0; i <= bch_pkg::t2; i++) begin
          lam[i]  <= (i == 0) ? bch_pkg::gf_t'(1) : bch_pkg::gf_t'(0);
          bpol[i] <= (i == 0) ? bch_pkg::gf_t'(1) : bch_pkg::gf_t'(0);
        end
        gamma <= bch_pkg::gf_t'(1);
        len   <= '0;
      end else if (busy) begin
        lam   <= lam_nxt;
        bpol  <= bpol_nxt;
        gamma <= gamma_nxt;
        len   <= len_nxt;
      end
      // syndromes and pointer are still held here
      if (last) begin
        for (int i = 0; i <= bch_pkg::t; i++) begin
          loc.poly[i] <= lam_nxt[i];
        end
        loc.deg     <= len_nxt;
        loc.decfail <= len_nxt > bch_pkg::addr_t'(bch_pkg::t);
        loc.ptr     <= syn.ptr;
      end
    end
  end

endmodule

/* rtl/bch_chien_search.sv */
//------------------------------------------------
// bch chien search and correction
// steps the locator terms per bit, reads the word
// back and flips the bits found at roots
//------------------------------------------------

`timescale 1ns/1ps

module bch_chien_search #(
  parameter int pBNUM_W = 2
) (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           iram_data,
  output logic           oram_read,
  output bch_pkg::ptr_t  oram_ptr,
  output bch_pkg::addr_t oram_addr,
  output logic           osop,
  output logic           oval,
  output logic           oeop,
  output logic           odat,
  output logic           odecfail,
  output bch_pkg::addr_t obiterr,
  loc_poly_if.dst        loc
);

  localparam bch_pkg::addr_t last_addr = bch_pkg::addr_t'(bch_pkg::n - 1);

  bch_pkg::gf_t       lam0;
  bch_pkg::gf_t       term [1:bch_pkg::t];
  bch_pkg::gf_t       sum;
  bch_pkg::addr_t     raddr;
  bch_pkg::addr_t     rcnt;
  bch_pkg::addr_t     rcnt_nxt;
  logic [pBNUM_W-1:0] bank;
  logic               busy;
  logic               fail;
  logic               root;
  logic               rd_val;
  logic               rd_first;
  logic               rd_last;

  // roots over all n positions, known before the first bit leaves
  function automatic bch_pkg::addr_t count_roots(input bch_pkg::gf_t p [0:bch_pkg::t]);
    bch_pkg::addr_t cnt;
    bch_pkg::gf_t   x;
    bch_pkg::gf_t   xp;
    bch_pkg::gf_t   s;
    cnt = '0;
    for (int i = 0; i < bch_pkg::n; i++) begin
      x  = bch_pkg::gf_alpha_pow(i);
      xp = x;
      s  = p[0];
      for (int j = 1; j <= bch_pkg::t; j++) begin
        s  = s ^ bch_pkg::gf_mult(p[j], xp);
        xp = bch_pkg::gf_mult(xp, x);
      end
      if (s == '0) begin
        cnt = cnt + 1'b1;
      end
    end
    return cnt;
  endfunction

  //------------------------------------------------
  // buffer read, address 0 goes out with loc val
  //------------------------------------------------

  assign oram_read = loc.val | busy;
  assign oram_addr = raddr;
  assign oram_ptr  = loc.val ? loc.ptr : bch_pkg::ptr_t'(bank);

  // step s tests alpha^(1+s), the inverse of position n-1-s
  always_comb begin
    sum = lam0;
    for (int j = 1; j <= bch_pkg::t; j++) begin
      sum = sum ^ term[j];
    end
  end

  assign root     = rd_val & (sum == '0);
  assign rcnt_nxt = (rd_first ? bch_pkg::addr_t'(0) : rcnt) + bch_pkg::addr_t'(root);

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      busy     <= 1'b0;
      raddr    <= '0;
      fail     <= 1'b0;
      rcnt     <= '0;
      rd_val   <= 1'b0;
      rd_first <= 1'b0;
      rd_last  <= 1'b0;
      osop     <= 1'b0;
      oval     <= 1'b0;
      oeop     <= 1'b0;
      odecfail <= 1'b0;
      obiterr  <= '0;
    end else if (iclkena) begin
      if (loc.val) begin
        busy <= 1'b1;
        fail <= loc.decfail | (count_roots(loc.poly) != loc.deg);
      end else if (busy & (raddr == last_addr)) begin
        busy <= 1'b0;
      end
      if (oram_read) begin
        raddr <= (raddr == last_addr) ? bch_pkg::addr_t'(0) : raddr + 1'b1;
      end
      // read data valid flags, one cycle behind the request
      rd_val   <= oram_read;
      rd_first <= loc.val;
      rd_last  <= oram_read & (raddr == last_addr);
      if (rd_val) begin
        rcnt <= rcnt_nxt;
      end
      oval     <= rd_val;
      osop     <= rd_first;
      oeop     <= rd_last;
      odecfail <= rd_last & fail;
      obiterr  <= (rd_last & ~fail) ? rcnt_nxt : bch_pkg::addr_t'(0);
    end
  end

  //------------------------------------------------
  // locator terms and corrected bit
  //------------------------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (loc.val) begin
        bank <= loc.ptr[pBNUM_W-1:0];
        lam0 <= loc.poly[0];
        for (int j = 1; j <= bch_pkg::t; j++) begin
          term[j] <= bch_pkg::gf_mult(loc.poly[j], bch_pkg::gf_alpha_pow(j));
        end
      end else if (rd_val) begin
        for (int j = 1; j <= bch_pkg::t; j++) begin
          term[j] <= bch_pkg::gf_mult(term[j], bch_pkg::gf_alpha_pow(j));
        end
      end
      // raw bit when the word is not decodable
      odat <= iram_data ^ (root & ~fail);
    end
  end

endmodule

/* rtl/bch_dec.sv */
//------------------------------------------------
// bch (15,7) decoder top level
// syndrome counter, berlekamp unit and chien
// search around a banked word buffer
//------------------------------------------------

`timescale 1ns/1ps

module bch_dec #(
  parameter int pBNUM_W = 2
) (
  input  logic           iclk,
  input  logic           ireset,
  input  logic           iclkena,
  input  logic           isop,
  input  logic           ival,
  input  logic           ieop,
  input  logic           idat,
  output logic           osop,
  output logic           oval,
  output logic           oeop,
  output logic           odat,
  output logic           odecfail,
  output bch_pkg::addr_t obiterr
);

  // buffer write side
  logic           ram_write;
  bch_pkg::ptr_t  ram_wptr;
  bch_pkg::addr_t ram_waddr;
  logic           ram_wdata;
  // buffer read side
  logic           ram_read;
  bch_pkg::ptr_t  ram_rptr;
  bch_pkg::addr_t ram_raddr;
  logic           ram_rdata;

  syndrome_if syn_bus ();
  loc_poly_if loc_bus ();

  //------------------------------------------------
  // word buffer, bank pointer follows each word
  //------------------------------------------------

  bch_buffer #(
    .pBNUM_W (pBNUM_W)
  ) u_buffer (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .iwrite  (ram_write),
    .iwptr   (ram_wptr),
    .iwaddr  (ram_waddr),
    .iwdata  (ram_wdata),
    .iread   (ram_read),
    .irptr   (ram_rptr),
    .iraddr  (ram_raddr),
    .ordata  (ram_rdata)
  );

  //------------------------------------------------
  // decoder stages
  //------------------------------------------------

  bch_syndrome_count #(
    .pBNUM_W (pBNUM_W)
  ) u_syndrome_count (
    .iclk       (iclk),
    .ireset     (ireset),
    .iclkena    (iclkena),
    .isop       (isop),
    .ival       (ival),
    .ieop       (ieop),
    .idat       (idat),
    .oram_write (ram_write),
    .oram_ptr   (ram_wptr),
    .oram_addr  (ram_waddr),
    .oram_data  (ram_wdata),
    .syn        (syn_bus.src)
  );

  bch_berlekamp u_berlekamp (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .syn     (syn_bus.dst),
    .loc     (loc_bus.src)
  );

  bch_chien_search #(
    .pBNUM_W (pBNUM_W)
  ) u_chien_search (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .iram_data (ram_rdata),
    .oram_read (ram_read),
    .oram_ptr  (ram_rptr),
    .oram_addr (ram_raddr),
    .osop      (osop),
    .oval      (oval),
    .oeop      (oeop),
    .odat      (odat),
    .odecfail  (odecfail),
    .obiterr   (obiterr),
    .loc       (loc_bus.dst)
  );

endmodule

/* test/bch_dec_sva.sv */
//------------------------------------------------
// bch decoder output protocol checks
// frame markers, word length, error count range
// and quiet outputs in reset
//------------------------------------------------

`timescale 1ns/1ps

module bch_dec_sva (
  input logic           iclk,
  input logic           ireset,
  input logic           iclkena,
  input logic           osop,
  input logic           oval,
  input logic           oeop,
  input logic           odecfail,
  input bch_pkg::addr_t obiterr
);

  localparam bch_pkg::addr_t last_beat = bch_pkg::addr_t'(bch_pkg::n);

  // beats already seen in the current word
  bch_pkg::addr_t beat_cnt;
  // position of the present beat, 1 .. n
  bch_pkg::addr_t beat_idx;

  assign beat_idx = osop ? bch_pkg::addr_t'(1) : beat_cnt + 1'b1;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      beat_cnt <= '0;
    end else if (iclkena & oval) begin
      beat_cnt <= oeop ? bch_pkg::addr_t'(0) : beat_idx;
    end
  end

  // markers ride on valid beats only
  a_marks_need_val : assert property (@(posedge iclk) disable iff (ireset)
    (osop | oeop) |-> oval)
    else $error("osop or oeop without oval");

  // a word opens with osop
  a_sop_first : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena & oval & (beat_cnt == '0)) |-> osop)
    else $error("valid beat outside a word");

  // oeop exactly on beat n
  a_eop_at_n : assert property (@(posedge iclk) disable iff (ireset)
    (iclkena & oval) |-> (oeop == (beat_idx == last_beat)))
    else $error("oeop not on beat n of the word");

  a_biterr_range : assert property (@(posedge iclk) disable iff (ireset)
    (oeop & ~odecfail) |-> (obiterr <= bch_pkg::addr_t'(bch_pkg::t)))
    else $error("obiterr above t on a decoded word");

  a_reset_quiet : assert property (@(posedge iclk)
    ireset |-> (!osop && !oval && !oeop && !odecfail && (obiterr == '0)))
    else $error("control outputs active in reset");

endmodule

bind bch_dec bch_dec_sva u_sva (
  .iclk     (iclk),
  .ireset   (ireset),
  .iclkena  (iclkena),
  .osop     (osop),
  .oval     (oval),
  .oeop     (oeop),
  .odecfail (odecfail),
  .obiterr  (obiterr)
);

/* test/tb_bch_dec.sv */
//------------------------------------------------
// bch (15,7) decoder testbench
// random frames from a reference encoder with
// injected errors, scoreboard on output words
//------------------------------------------------

`timescale 1ns/1ps

module tb_bch_dec;

  // generator x^8 + x^7 + x^6 + x^4 + 1
  localparam logic [8:0] gen_poly    = 9'h1D1;
  localparam int         gen_deg     = 8;
  localparam int         n_clean     = 4;
  localparam int         n_corr      = 12;
  localparam int         n_over      = 8;
  localparam int         n_gated     = 16;
  localparam int         frame_total = n_clean + n_corr + n_over + n_gated;
  // gated frames stretch to about twice their length
  localparam int         cycle_limit = frame_total * (bch_pkg::n + bch_pkg::t2 + 8) * 2 + 500;

  logic           iclk = 1'b0;
  logic           ireset;
  logic           iclkena;
  logic           isop;
  logic           ival;
  logic           ieop;
  logic           idat;
  logic           osop;
  logic           oval;
  logic           oeop;
  logic           odat;
  logic           odecfail;
  bch_pkg::addr_t obiterr;

  int seed    = 41431;
  int errors  = 0;
  int frames  = 0;
  int cycles  = 0;
  int ena_cnt = 0;
  int beat    = 0;
  int lat;
  int err0;

  logic [bch_pkg::n-1:0] out_word;
  // scoreboard, one entry per frame sent
  logic [bch_pkg::n-1:0] exp_q   [$];
  logic [bch_pkg::n-1:0] rx_q    [$];
  int                    nflip_q [$];
  // enabled cycle count at each ieop beat
  int                    eop_q   [$];

  bch_dec #(
    .pBNUM_W (2)
  ) u_dut (
    .iclk     (iclk),
    .ireset   (ireset),
    .iclkena  (iclkena),
    .isop     (isop),
    .ival     (ival),
    .ieop     (ieop),
    .idat     (idat),
    .osop     (osop),
    .oval     (oval),
    .oeop     (oeop),
    .odat     (odat),
    .odecfail (odecfail),
    .obiterr  (obiterr)
  );

  always #2 iclk = ~iclk;

  //------------------------------------------------
  // reference code and error reporting
  //------------------------------------------------

  task automatic report_mismatch(input string msg);
    $display("FAILED %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_problem(input string msg);
    $display("error: %s", msg);
    errors++;
  endtask

  // remainder of a word by the generator, zero for a codeword
  function automatic logic [gen_deg-1:0] poly_rem(input logic [bch_pkg::n-1:0] w);
    logic [bch_pkg::n-1:0] r;
    r = w;
    for (int i = bch_pkg::n - 1; i >= gen_deg; i--) begin
      if (r[i]) begin
        r = r ^ ({6'b0, gen_poly} << (i - gen_deg));
      end
    end
    return r[gen_deg-1:0];
  endfunction

  // systematic, message in the high bits
  function automatic logic [bch_pkg::n-1:0] encode(input logic [bch_pkg::k-1:0] msg);
    return {msg, poly_rem({msg, 8'b0})};
  endfunction

  //------------------------------------------------
  // stimulus
  //------------------------------------------------

  // repeats the beat until an enabled edge takes it
  task automatic drive_beat(input logic sop, input logic eop, input logic b,
                            input logic gated);
    logic en;
    en = 1'b1;
    do begin
      if (gated) begin
        en = ({$random(seed)} % 4) != 0;
      end
      iclkena = en;
      isop    = sop;
      ival    = 1'b1;
      ieop    = eop;
      idat    = b;
      @(posedge iclk);
      #1;
    end while (!en);
  endtask

  task automatic drive_idle(input logic gated);
    iclkena = gated ? (({$random(seed)} % 4) != 0) : 1'b1;
    isop    = 1'b0;
    ival    = 1'b0;
    ieop    = 1'b0;
    idat    = 1'b0;
    @(posedge iclk);
    #1;
  endtask

  task automatic send_frame(input int nflip, input logic gated);
    logic [bch_pkg::k-1:0] msg;
    logic [bch_pkg::n-1:0] code;
    logic [bch_pkg::n-1:0] mask;
    int                    pos;
    int                    cnt;
    msg  = bch_pkg::k'($random(seed));
    code = encode(msg);
    mask = '0;
    cnt  = 0;
    // distinct error positions
    while (cnt < nflip) begin
      pos = {$random(seed)} % bch_pkg::n;
      if (!mask[pos]) begin
        mask[pos] = 1'b1;
        cnt++;
      end
    end
    exp_q.push_back(code);
    rx_q.push_back(code ^ mask);
    nflip_q.push_back(nflip);
    frames++;
    // highest degree coefficient first
    for (int i = bch_pkg::n - 1; i >= 0; i--) begin
      drive_beat(i == bch_pkg::n - 1, i == 0, code[i] ^ mask[i], gated);
    end
  endtask

  // frames back to back, then wait for the last word
  task automatic run_frames(input int id, input string name, input int count,
                            input int nmin, input int nmax, input logic gated);
    int e0;
    int nf;
    e0 = errors;
    for (int f = 0; f < count; f++) begin
      nf = nmin + int'({$random(seed)} % (nmax - nmin + 1));
      send_frame(nf, gated);
    end
    while (exp_q.size() != 0) begin
      drive_idle(gated);
    end
    repeat (4) drive_idle(gated);
    $display("test %0d %s: %0d frames, %0d errors", id, name, count, errors - e0);
  endtask

  //------------------------------------------------
  // output monitor and scoreboard
  //------------------------------------------------

  task automatic score_word(input logic [bch_pkg::n-1:0] got, input logic fail,
                            input bch_pkg::addr_t nerr);
    logic [bch_pkg::n-1:0] exp_w;
    logic [bch_pkg::n-1:0] rx_w;
    int                    nf;
    if (exp_q.size() == 0) begin
      report_problem("decoder put out a word while no frame was pending");
    end else begin
      exp_w = exp_q.pop_front();
      rx_w  = rx_q.pop_front();
      nf    = nflip_q.pop_front();
      if (nf <= bch_pkg::t) begin
        assert (got == exp_w)
          else report_mismatch($sformatf("word %h, expected %h", got, exp_w));
        assert (!fail)
          else report_mismatch($sformatf("odecfail set with %0d flips", nf));
        assert (int'(nerr) == nf)
          else report_mismatch($sformatf("obiterr %0d, expected %0d", nerr, nf));
      end else if (fail) begin
        // detected, raw bits pass through
        assert (got == rx_w)
          else report_mismatch($sformatf("word %h, expected raw %h", got, rx_w));
        assert (nerr == '0)
          else report_mismatch($sformatf("obiterr %0d on a failed word", nerr));
      end else begin
        // miscorrection must still land on a codeword
        assert (poly_rem(got) == '0)
          else report_mismatch($sformatf("word %h is not a codeword", got));
      end
    end
  endtask

  // pre-edge values, one beat per enabled edge
  always @(posedge iclk) begin
    if (!ireset && iclkena) begin
      if (ival && ieop) begin
        eop_q.push_back(ena_cnt);
      end
      if (oval) begin
        if (osop) begin
          assert (beat == 0)
            else report_mismatch($sformatf("osop at beat %0d of a word", beat));
          if (eop_q.size() == 0) begin
            report_problem("osop came with no frame sent");
          end else begin
            lat = ena_cnt - eop_q.pop_front();
            assert (lat == bch_pkg::t2 + 4)
              else report_mismatch($sformatf("ieop to osop %0d cycles, expected %0d",
                                             lat, bch_pkg::t2 + 4));
          end
          beat     = 0;
          out_word = '0;
        end
        if (beat < bch_pkg::n) begin
          out_word[bch_pkg::n - 1 - beat] = odat;
        end
        beat++;
        if (oeop) begin
          assert (beat == bch_pkg::n)
            else report_mismatch($sformatf("word of %0d beats", beat));
          score_word(out_word, odecfail, obiterr);
          beat = 0;
        end
      end
      ena_cnt++;
    end
  end

  // run limit
  always @(posedge iclk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: decoder did not deliver all words within %0d cycles", cycle_limit);
      $display("TEST FAIL");
      $finish;
    end
  end

  //------------------------------------------------
  // test sequence
  //------------------------------------------------

  initial begin
    ireset  = 1'b0;
    iclkena = 1'b1;
    isop    = 1'b0;
    ival    = 1'b0;
    ieop    = 1'b0;
    idat    = 1'b0;
    #1;
    ireset  = 1'b1;
    repeat (5) @(posedge iclk);
    #1;
    ireset  = 1'b0;

    // quiet outputs with no input
    err0 = errors;
    repeat (20) begin
      @(negedge iclk);
      assert (!oval && !osop && !oeop && !odecfail)
        else report_mismatch("output control active with no input");
    end
    @(posedge iclk);
    #1;
    $display("test 1 idle after reset: %0d errors", errors - err0);

    run_frames(2, "clean codewords", n_clean, 0, 0, 1'b0);
    run_frames(3, "one or two flips", n_corr, 1, 2, 1'b0);
    run_frames(4, "three flips", n_over, 3, 3, 1'b0);
    run_frames(5, "back to back gated", n_gated, 0, 2, 1'b1);

    $display("done: 5 tests, %0d frames, %0d errors", frames, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* files.f */
rtl/bch_pkg.sv
rtl/bch_if.sv
rtl/bch_buffer.sv
rtl/bch_syndrome_count.sv
rtl/bch_berlekamp.sv
rtl/bch_chien_search.sv
rtl/bch_dec.sv
test/bch_dec_sva.sv
test/tb_bch_dec.sv

/* run.sh */
#!/bin/sh
# build and run the bch decoder testbench with verilator
rm -f sim.log
verilator --binary --assert --top-module tb_bch_dec -f files.f \
  && ./obj_dir/Vtb_bch_dec > sim.log 2>&1 \
  || echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -qs "^TEST PASS$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
